//--- filelist.f
fetch_pkg.sv
instr_if.sv
opcode_decoder.sv
fetch_parser.sv
instr_queue.sv
operand_resolver.sv
fetch_decode_top.sv
tb_fetch_decode_assertions.sv
tb_fetch_decode.sv

//--- tb_fetch_decode.sv
`timescale 1ns/1ps

module tb_fetch_decode import fetch_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      byte_valid;
  byte_t     byte_data;
  logic      byte_ready;
  logic      out_ready;
  logic      out_valid;
  op_class_e out_op_class;
  alu_op_e   out_alu_op;
  logic      out_byte_w;
  reg_code_t out_dst;
  reg_code_t out_src;
  logic      out_mem;
  reg_code_t out_base;
  reg_code_t out_index;
  seg_code_t out_seg;
  word_t     out_off;
  word_t     out_imm;

  byte_t     byte_q [$];
  int        len_q [$];
  resolved_t exp_q [$];
  byte_t     nop_list [8] = '{8'h00, 8'h0E, 8'h26, 8'h40, 8'h90, 8'hC3, 8'hF5, 8'hFA};
  int        seed = 15;
  int        ready_seed = 15;
  int        stall_left = 0;
  int        n_instr = 400;
  int        n_checked = 0;
  int        n_errors = 0;
  int        n_assert = 0;
  logic      timed_out = 1'b0;

  fetch_decode_top dut (
    .clk            (clk),
    .rst            (rst),
    .byte_valid_i   (byte_valid),
    .byte_data_i    (byte_data),
    .byte_ready_o   (byte_ready),
    .out_ready_i    (out_ready),
    .out_valid_o    (out_valid),
    .out_op_class_o (out_op_class),
    .out_alu_op_o   (out_alu_op),
    .out_byte_w_o   (out_byte_w),
    .out_dst_o      (out_dst),
    .out_src_o      (out_src),
    .out_mem_o      (out_mem),
    .out_base_o     (out_base),
    .out_index_o    (out_index),
    .out_seg_o      (out_seg),
    .out_off_o      (out_off),
    .out_imm_o      (out_imm)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic resolved_t expected_resolve(input op_class_e cls, input alu_op_e alu,
                                                 input byte_t opc, input byte_t modrm,
                                                 input word_t off, input word_t imm);
    resolved_t r;
    reg_code_t reg_f;
    reg_code_t rm_f;
    r.op_class = cls;
    r.alu_op   = alu;
    r.byte_w   = (cls == OP_MOV_IMM) ? !opc[3] : !opc[0];
    r.dst      = REG_NONE;
    r.src      = REG_NONE;
    r.mem      = 1'b0;
    r.base     = REG_NONE;
    r.index    = REG_NONE;
    r.seg      = SEG_DS;
    r.off      = off;
    r.imm      = imm;
    if (cls == OP_ALU_RM || cls == OP_MOV_RM)
    begin
      r.mem = (modrm[7:6] != 2'b11);
      reg_f = {1'b0, modrm[5:3]};
      rm_f  = r.mem ? REG_NONE : {1'b0, modrm[2:0]};
      r.dst = opc[1] ? reg_f : rm_f;  // reg is destination when d is set
      r.src = opc[1] ? rm_f : reg_f;
      if (r.mem)
      begin
        case (modrm[2:0])
          3'd0, 3'd1, 3'd7: r.base = REG_BX;
          3'd2, 3'd3:       r.base = REG_BP;
          3'd6:             r.base = (modrm[7:6] == 2'b00) ? REG_NONE : REG_BP;
          default:          r.base = REG_NONE;
        endcase
        case (modrm[2:0])
          3'd0, 3'd2, 3'd4: r.index = REG_SI;
          3'd1, 3'd3, 3'd5: r.index = REG_DI;
          default:          r.index = REG_NONE;
        endcase
        if (r.base == REG_BP)
          r.seg = SEG_SS;  // bp based goes through ss
      end
    end
    else if (cls == OP_ALU_ACC)
    begin
      r.dst = REG_AX;
      r.src = REG_AX;
    end
    else if (cls == OP_MOV_IMM || cls == OP_POP)
      r.dst = {1'b0, opc[2:0]};
    else if (cls == OP_PUSH)
      r.src = {1'b0, opc[2:0]};
    return r;
  endfunction

  // little-endian field with short ones zero-extended
  task automatic push_field(input int len, output word_t val);
    byte_t b;
    val = '0;
    if (len > 0)
    begin
      b = byte_t'($random(seed));
      byte_q.push_back(b);
      val[7:0] = b;
    end
    if (len == 2)
    begin
      b = byte_t'($random(seed));
      byte_q.push_back(b);
      val[15:8] = b;
    end
  endtask

  task automatic add_instr;
    op_class_e cls;
    alu_op_e   alu;
    byte_t     opc;
    byte_t     base;
    byte_t     modrm;
    word_t     off;
    word_t     imm;
    int        sel;
    int        len;
    int        first;
    first = byte_q.size();
    cls   = op_class_e'({$random(seed)} % 10);
    sel   = {$random(seed)} % 3;
    opc   = byte_t'($random(seed));
    modrm = 8'h00;
    off   = '0;
    imm   = '0;
    alu   = ALU_NONE;
    base  = (sel == 0) ? 8'h08 : (sel == 1) ? 8'h20 : 8'h30;
    case (cls)
      OP_ALU_RM:
      begin
        alu = (sel == 0) ? ALU_OR : (sel == 1) ? ALU_AND : ALU_XOR;
        opc = base | (opc & 8'h03);
      end
      OP_ALU_ACC:
      begin
        alu = (sel == 0) ? ALU_OR : (sel == 1) ? ALU_AND : ALU_XOR;
        opc = base + 8'h04 + (opc & 8'h01);
      end
      OP_MOV_RM:
      begin
        alu = ALU_MOV;
        opc = 8'h88 | (opc & 8'h03);
      end
      OP_MOV_IMM:
      begin
        alu = ALU_MOV;
        opc = 8'hB0 | (opc & 8'h0F);
      end
      OP_PUSH:  opc = 8'h50 | (opc & 8'h07);
      OP_POP:   opc = 8'h58 | (opc & 8'h07);
      OP_JCC:   opc = 8'h70 | (opc & 8'h0F);
      OP_CALLF: opc = 8'h9A;
      OP_HLT:   opc = 8'hF4;
      default:  opc = nop_list[opc[2:0]];  // opcode not in the table
    endcase
    byte_q.push_back(opc);
    if (cls == OP_ALU_RM || cls == OP_MOV_RM)
    begin
      modrm = byte_t'($random(seed));
      byte_q.push_back(modrm);
      len = (modrm[7:6] == 2'b01) ? 1 : (modrm[7:6] == 2'b10) ? 2 :
            (modrm[7:6] == 2'b00 && modrm[2:0] == 3'b110) ? 2 : 0;
      push_field(len, off);
    end
    else if (cls == OP_CALLF)
    begin
      push_field(2, off);
      push_field(2, imm);
    end
    else if (cls == OP_JCC)
      push_field(1, imm);
    else if (cls == OP_ALU_ACC)
      push_field(opc[0] ? 2 : 1, imm);
    else if (cls == OP_MOV_IMM)
      push_field(opc[3] ? 2 : 1, imm);
    len_q.push_back(byte_q.size() - first);
    exp_q.push_back(expected_resolve(cls, alu, opc, modrm, off, imm));
  endtask

  task automatic check_class(input op_class_e got, input op_class_e exp, input string what);
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s is %s, expected %s", $time, what, got.name(),
               exp.name());
    end
  endtask

  task automatic check_alu(input alu_op_e got, input alu_op_e exp, input string what);
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s is %s, expected %s", $time, what, got.name(),
               exp.name());
    end
  endtask

  task automatic check_reg(input reg_code_t got, input reg_code_t exp, input string what);
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_seg(input seg_code_t got, input seg_code_t exp, input string what);
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_result(input resolved_t exp);
    string tag;
    tag = $sformatf("instr %0d", n_checked);
    check_class(out_op_class, exp.op_class, {tag, " class"});
    check_alu(out_alu_op, exp.alu_op, {tag, " alu op"});
    check_bit(out_byte_w, exp.byte_w, {tag, " byte_w"});
    check_reg(out_dst, exp.dst, {tag, " dst"});
    check_reg(out_src, exp.src, {tag, " src"});
    check_bit(out_mem, exp.mem, {tag, " mem"});
    check_reg(out_base, exp.base, {tag, " base"});
    check_reg(out_index, exp.index, {tag, " index"});
    check_seg(out_seg, exp.seg, {tag, " seg"});
    check_word(out_off, exp.off, {tag, " off"});
    check_word(out_imm, exp.imm, {tag, " imm"});
  endtask

  task automatic print_counts;
    n_assert = dut.u_resolver.u_assert.fail_count;
    $display("results: %0d of %0d checked, %0d check errors, %0d assertion errors",
             n_checked, n_instr, n_errors, n_assert);
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("timeout at %0t ns: %s", $time, what);
  endtask

  task automatic drive_bytes;
    int waited;
    int left;
    left = 0;
    while (byte_q.size() != 0 && !timed_out)
    begin
      if (left == 0)
        left = len_q.pop_front();
      if ({$random(seed)} % 4 == 0)
      begin
        byte_valid = 1'b0;  // idle cycle
        @(negedge clk);
      end
      byte_valid = 1'b1;
      byte_data  = byte_q.pop_front();
      waited     = 0;
      while (!byte_ready && !timed_out)
      begin
        @(negedge clk);
        waited++;
        if (waited > 4000)
          report_timeout("the byte input never became ready");
      end
      if (!timed_out)
      begin
        @(negedge clk);  // taken on the edge just passed
        left--;
        if (left == 0)
          check_bit(byte_ready, 1'b0, "byte_ready after the last byte of an instruction");
      end
    end
    byte_valid = 1'b0;
  endtask

  // long stalls now and then so the queue fills up
  task automatic set_out_ready;
    if (stall_left > 0)
    begin
      out_ready = 1'b0;
      stall_left--;
    end
    else if ({$random(ready_seed)} % 50 == 0)
    begin
      out_ready  = 1'b0;
      stall_left = 40 + {$random(ready_seed)} % 40;
    end
    else
      out_ready = ({$random(ready_seed)} % 4) != 0;
  endtask

  task automatic sink_outputs;
    int idle;
    idle = 0;
    while (n_checked < n_instr && !timed_out)
    begin
      @(negedge clk);
      set_out_ready();
      if (out_valid && out_ready)  // transfer on the next rising edge
      begin
        compare_result(exp_q.pop_front());
        n_checked++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > 4000)
          report_timeout("no result arrived on the output for 4000 cycles");
      end
    end
    out_ready = 1'b1;
    if (!timed_out)
    begin
      repeat (20)
      begin
        @(negedge clk);
        if (out_valid)
        begin
          n_errors++;
          $display("extra result on the output at %0t ns after the last instruction", $time);
        end
      end
    end
  endtask

  initial
  begin
    rst        = 1'b1;
    byte_valid = 1'b0;
    byte_data  = '0;
    out_ready  = 1'b0;
    repeat (n_instr)
      add_instr();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_bit(byte_ready, 1'b1, "byte_ready after reset");
    check_bit(out_valid, 1'b0, "out_valid after reset");
    rst = 1'b0;
    fork
      drive_bytes();
      sink_outputs();
    join
    print_counts();
    if (!timed_out && n_errors == 0 && n_assert == 0 && n_checked == n_instr)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- tb_fetch_decode_assertions.sv
`timescale 1ns/1ps

module tb_fetch_decode_assertions (
  input logic        clk,
  input logic        rst,
  input logic        valid_i,
  input logic        ready_i,
  input logic [58:0] payload_i
);

  int unsigned fail_count = 0;

  a_reset_valid: assert property (@(posedge clk) rst |=> !valid_i)
    else
    begin
      fail_count++;
      $error("out_valid_o not low after reset");
    end

  // held result under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (rst)
                           valid_i && !ready_i |=> valid_i && $stable(payload_i))
    else
    begin
      fail_count++;
      $error("result changed or dropped while out_ready_i was low");
    end

  a_known: assert property (@(posedge clk) disable iff (rst) valid_i |-> !$isunknown(payload_i))
    else
    begin
      fail_count++;
      $error("unknown bits on the result while out_valid_o is high");
    end

endmodule

bind operand_resolver tb_fetch_decode_assertions u_assert (
  .clk       (clk),
  .rst       (rst),
  .valid_i   (out_valid_o),
  .ready_i   (out_ready_i),
  .payload_i ({out_op_class_o, out_alu_op_o, out_byte_w_o, out_dst_o, out_src_o, out_mem_o,
               out_base_o, out_index_o, out_seg_o, out_off_o, out_imm_o})
);

//--- fetch_decode_top.sv
`timescale 1ns/1ps

module fetch_decode_top import fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      byte_valid_i,
  input  byte_t     byte_data_i,
  output logic      byte_ready_o,
  input  logic      out_ready_i,
  output logic      out_valid_o,
  output op_class_e out_op_class_o,
  output alu_op_e   out_alu_op_o,
  output logic      out_byte_w_o,
  output reg_code_t out_dst_o,
  output reg_code_t out_src_o,
  output logic      out_mem_o,
  output reg_code_t out_base_o,
  output reg_code_t out_index_o,
  output seg_code_t out_seg_o,
  output word_t     out_off_o,
  output word_t     out_imm_o
);

  instr_if parse_if ();  // parser to queue
  instr_if queue_if ();  // queue to resolver

  fetch_parser u_parser (
    .clk          (clk),
    .rst          (rst),
    .byte_valid_i (byte_valid_i),
    .byte_data_i  (byte_data_i),
    .byte_ready_o (byte_ready_o),
    .out_o        (parse_if.producer)
  );

  instr_queue u_queue (
    .clk   (clk),
    .rst   (rst),
    .in_i  (parse_if.consumer),
    .out_o (queue_if.producer)
  );

  operand_resolver u_resolver (
    .clk            (clk),
    .rst            (rst),
    .in_i           (queue_if.consumer),
    .out_ready_i    (out_ready_i),
    .out_valid_o    (out_valid_o),
    .out_op_class_o (out_op_class_o),
    .out_alu_op_o   (out_alu_op_o),
    .out_byte_w_o   (out_byte_w_o),
    .out_dst_o      (out_dst_o),
    .out_src_o      (out_src_o),
    .out_mem_o      (out_mem_o),
    .out_base_o     (out_base_o),
    .out_index_o    (out_index_o),
    .out_seg_o      (out_seg_o),
    .out_off_o      (out_off_o),
    .out_imm_o      (out_imm_o)
  );

endmodule

//--- operand_resolver.sv
`timescale 1ns/1ps

module operand_resolver import fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  instr_if.consumer in_i,
  input  logic      out_ready_i,
  output logic      out_valid_o,
  output op_class_e out_op_class_o,
  output alu_op_e   out_alu_op_o,
  output logic      out_byte_w_o,
  output reg_code_t out_dst_o,
  output reg_code_t out_src_o,
  output logic      out_mem_o,
  output reg_code_t out_base_o,
  output reg_code_t out_index_o,
  output seg_code_t out_seg_o,
  output word_t     out_off_o,
  output word_t     out_imm_o
);

  logic [1:0] mod;
  logic [2:0] rm;
  logic       d_bit;
  logic       rm_is_mem;
  reg_code_t  reg_code;
  reg_code_t  rm_code;
  reg_code_t  opc_reg;
  reg_code_t  dst, src, base, index;
  seg_code_t  seg;
  logic       mem;
  logic       take;

  assign mod       = in_i.modrm[7:6];
  assign rm        = in_i.modrm[2:0];
  assign d_bit     = in_i.opcode[1];
  assign rm_is_mem = (mod != 2'b11);
  assign reg_code  = {1'b0, in_i.modrm[5:3]};
  assign rm_code   = rm_is_mem ? REG_NONE : {1'b0, rm};
  assign opc_reg   = {1'b0, in_i.opcode[2:0]};  // short register forms

  always_comb
  begin
    dst = REG_NONE;
    src = REG_NONE;
    mem = 1'b0;
    case (in_i.op_class)
      OP_ALU_RM, OP_MOV_RM:
      begin
        dst = d_bit ? reg_code : rm_code;
        src = d_bit ? rm_code : reg_code;
        mem = rm_is_mem;
      end
      OP_ALU_ACC:
      begin
        dst = REG_AX;
        src = REG_AX;
      end
      OP_MOV_IMM, OP_POP: dst = opc_reg;
      OP_PUSH:            src = opc_reg;
      default:            ;
    endcase
  end

  always_comb
  begin
    base  = REG_NONE;
    index = REG_NONE;
    seg   = SEG_DS;
    if (mem)
    begin
      case (rm)
        3'd0: begin base = REG_BX; index = REG_SI; end
        3'd1: begin base = REG_BX; index = REG_DI; end
        3'd2: begin base = REG_BP; index = REG_SI; seg = SEG_SS; end
        3'd3: begin base = REG_BP; index = REG_DI; seg = SEG_SS; end
        3'd4: index = REG_SI;
        3'd5: index = REG_DI;
        3'd6:
        begin
          base = (mod == 2'b00) ? REG_NONE : REG_BP;  // mod 00 is disp16 only
          seg  = (mod == 2'b00) ? SEG_DS : SEG_SS;
        end
        default: base = REG_BX;
      endcase
    end
  end

  assign in_i.ready = !out_valid_o || out_ready_i;
  assign take       = in_i.valid && in_i.ready;

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid_o <= 1'b0;
    else if (take)
      out_valid_o <= 1'b1;
    else if (out_ready_i)
      out_valid_o <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      out_op_class_o <= in_i.op_class;
      out_alu_op_o   <= in_i.alu_op;
      out_byte_w_o   <= in_i.byte_w;
      out_dst_o      <= dst;
      out_src_o      <= src;
      out_mem_o      <= mem;
      out_base_o     <= base;
      out_index_o    <= index;
      out_seg_o      <= seg;
      out_off_o      <= in_i.off;
      out_imm_o      <= in_i.imm;
    end
  end

endmodule

//--- instr_queue.sv
`timescale 1ns/1ps

module instr_queue import fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  instr_if.consumer in_i,
  instr_if.producer out_o
);

  typedef struct packed {
    byte_t     opcode;
    byte_t     modrm;
    word_t     off;
    word_t     imm;
    op_class_e op_class;
    alu_op_e   alu_op;
    logic      byte_w;
  } entry_t;

  entry_t              mem_q [QUEUE_DEPTH];
  logic [QPTR_W-1:0]   wr_ptr_q;
  logic [QPTR_W-1:0]   rd_ptr_q;
  logic [QPTR_W:0]     count_q;
  logic                wr_en;
  logic                rd_en;
  entry_t              head;

  assign out_o.valid = (count_q != '0);
  assign in_i.ready  = (count_q != QUEUE_DEPTH) || out_o.ready;  // write with read when full
  assign wr_en       = in_i.valid && in_i.ready;
  assign rd_en       = out_o.valid && out_o.ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem_q[wr_ptr_q] <= '{opcode: in_i.opcode, modrm: in_i.modrm, off: in_i.off,
                           imm: in_i.imm, op_class: in_i.op_class,
                           alu_op: in_i.alu_op, byte_w: in_i.byte_w};
  end

  assign head           = mem_q[rd_ptr_q];
  assign out_o.opcode   = head.opcode;
  assign out_o.modrm    = head.modrm;
  assign out_o.off      = head.off;
  assign out_o.imm      = head.imm;
  assign out_o.op_class = head.op_class;
  assign out_o.alu_op   = head.alu_op;
  assign out_o.byte_w   = head.byte_w;

endmodule

//--- fetch_parser.sv
`timescale 1ns/1ps

module fetch_parser import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            byte_valid_i,
  input  byte_t           byte_data_i,
  output logic            byte_ready_o,
  instr_if.producer       out_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  fetch_state_e after_modrm;
  fetch_state_e after_off;
  logic         cnt_q;        // second byte of a 16-bit field
  logic         take;
  logic         field_last;
  logic [1:0]   field_len;

  byte_t     opcode_q;
  byte_t     modrm_q;
  word_t     off_q;
  word_t     imm_q;
  op_class_e class_q;
  alu_op_e   alu_q;
  logic      byte_w_q;

  byte_t      dec_opcode;
  byte_t      dec_modrm;
  op_class_e  dec_class;
  alu_op_e    dec_alu;
  logic       dec_byte_w;
  logic       need_modrm;
  logic [1:0] off_len;
  logic [1:0] imm_len;

  // incoming byte is decoded directly while in opcode/modrm states
  assign dec_opcode = (state_q == ST_OPCODE) ? byte_data_i : opcode_q;
  assign dec_modrm  = (state_q == ST_MODRM) ? byte_data_i : modrm_q;

  opcode_decoder u_decoder (
    .opcode_i     (dec_opcode),
    .modrm_i      (dec_modrm),
    .op_class_o   (dec_class),
    .alu_op_o     (dec_alu),
    .byte_w_o     (dec_byte_w),
    .need_modrm_o (need_modrm),
    .off_len_o    (off_len),
    .imm_len_o    (imm_len)
  );

  assign byte_ready_o = (state_q != ST_PUSH);
  assign take         = byte_valid_i && byte_ready_o;

  assign field_len  = (state_q == ST_OFFSET) ? off_len : imm_len;
  assign field_last = ({1'b0, cnt_q} + 2'd1) == field_len;

  assign after_off   = (imm_len != 2'd0) ? ST_IMMED : ST_PUSH;
  assign after_modrm = (off_len != 2'd0) ? ST_OFFSET : after_off;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_OPCODE: if (take) state_d = need_modrm ? ST_MODRM : after_modrm;
      ST_MODRM:  if (take) state_d = after_modrm;
      ST_OFFSET: if (take && field_last) state_d = after_off;
      ST_IMMED:  if (take && field_last) state_d = ST_PUSH;
      ST_PUSH:   if (out_o.ready) state_d = ST_OPCODE;
      default:   state_d = ST_OPCODE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ST_OPCODE;
      cnt_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (take && (state_q == ST_OFFSET || state_q == ST_IMMED))
        cnt_q <= !field_last;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      case (state_q)
        ST_OPCODE:
        begin
          opcode_q <= byte_data_i;
          modrm_q  <= '0;
          off_q    <= '0;  // short disp is zero-extended
          imm_q    <= '0;
        end
        ST_MODRM:  modrm_q <= byte_data_i;
        ST_OFFSET: if (cnt_q) off_q[15:8] <= byte_data_i; else off_q[7:0] <= byte_data_i;
        ST_IMMED:  if (cnt_q) imm_q[15:8] <= byte_data_i; else imm_q[7:0] <= byte_data_i;
        default:   ;
      endcase
      class_q  <= dec_class;
      alu_q    <= dec_alu;
      byte_w_q <= dec_byte_w;
    end
  end

  assign out_o.valid    = (state_q == ST_PUSH);
  assign out_o.opcode   = opcode_q;
  assign out_o.modrm    = modrm_q;
  assign out_o.off      = off_q;
  assign out_o.imm      = imm_q;
  assign out_o.op_class = class_q;
  assign out_o.alu_op   = alu_q;
  assign out_o.byte_w   = byte_w_q;

endmodule

//--- opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder import fetch_pkg::*; (
  input  byte_t      opcode_i,
  input  byte_t      modrm_i,
  output op_class_e  op_class_o,
  output alu_op_e    alu_op_o,
  output logic       byte_w_o,
  output logic       need_modrm_o,
  output logic [1:0] off_len_o,
  output logic [1:0] imm_len_o
);

  logic [1:0] mod;
  logic [2:0] rm;
  logic [1:0] disp_len;
  logic [1:0] wide_len;
  logic       mov_imm;
  alu_op_e    alu_sel;

  assign mod = modrm_i[7:6];
  assign rm  = modrm_i[2:0];

  assign mov_imm  = (opcode_i[7:4] == 4'b1011);
  assign byte_w_o = mov_imm ? ~opcode_i[3] : ~opcode_i[0];  // w bit moves for mov imm
  assign wide_len = byte_w_o ? 2'd1 : 2'd2;

  always_comb
  begin
    case (mod)
      2'b01:   disp_len = 2'd1;
      2'b10:   disp_len = 2'd2;
      2'b00:   disp_len = (rm == 3'b110) ? 2'd2 : 2'd0;  // direct address
      default: disp_len = 2'd0;
    endcase
  end

  always_comb
  begin
    case (opcode_i[5:4])
      2'b00:   alu_sel = ALU_OR;
      2'b10:   alu_sel = ALU_AND;
      2'b11:   alu_sel = ALU_XOR;
      default: alu_sel = ALU_NONE;
    endcase
  end

  always_comb
  begin
    op_class_o   = OP_NOP;
    alu_op_o     = ALU_NONE;
    need_modrm_o = 1'b0;
    off_len_o    = 2'd0;
    imm_len_o    = 2'd0;
    casez (opcode_i)
      8'b0000_10??, 8'b0010_00??, 8'b0011_00??:  // or/and/xor r/m
      begin
        op_class_o   = OP_ALU_RM;
        alu_op_o     = alu_sel;
        need_modrm_o = 1'b1;
        off_len_o    = disp_len;
      end
      8'b0000_110?, 8'b0010_010?, 8'b0011_010?:  // accumulator immediate
      begin
        op_class_o = OP_ALU_ACC;
        alu_op_o   = alu_sel;
        imm_len_o  = wide_len;
      end
      8'b1000_10??:
      begin
        op_class_o   = OP_MOV_RM;
        alu_op_o     = ALU_MOV;
        need_modrm_o = 1'b1;
        off_len_o    = disp_len;
      end
      8'b1011_????:
      begin
        op_class_o = OP_MOV_IMM;
        alu_op_o   = ALU_MOV;
        imm_len_o  = wide_len;
      end
      8'b0101_0???: op_class_o = OP_PUSH;
      8'b0101_1???: op_class_o = OP_POP;
      8'b0111_????:
      begin
        op_class_o = OP_JCC;
        imm_len_o  = 2'd1;  // rel8
      end
      OPC_CALLF:
      begin
        op_class_o = OP_CALLF;
        off_len_o  = 2'd2;
        imm_len_o  = 2'd2;
      end
      OPC_HLT:  op_class_o = OP_HLT;
      default:  op_class_o = OP_NOP;
    endcase
  end

endmodule

//--- instr_if.sv
`timescale 1ns/1ps

interface instr_if import fetch_pkg::*; ();

  logic      valid;
  logic      ready;
  byte_t     opcode;
  byte_t     modrm;
  word_t     off;
  word_t     imm;
  op_class_e op_class;
  alu_op_e   alu_op;
  logic      byte_w;

  modport producer (output valid, opcode, modrm, off, imm, op_class, alu_op, byte_w,
                    input ready);

  modport consumer (input valid, opcode, modrm, off, imm, op_class, alu_op, byte_w,
                    output ready);

endinterface

//--- fetch_pkg.sv
package fetch_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  // 0-7 general registers, 8-11 segment registers
  typedef logic [3:0] reg_code_t;
  typedef logic [1:0] seg_code_t;

  localparam reg_code_t REG_AX   = 4'd0;
  localparam reg_code_t REG_BX   = 4'd3;
  localparam reg_code_t REG_BP   = 4'd5;
  localparam reg_code_t REG_SI   = 4'd6;
  localparam reg_code_t REG_DI   = 4'd7;
  localparam reg_code_t REG_NONE = 4'd12;

  localparam seg_code_t SEG_SS = 2'd2;
  localparam seg_code_t SEG_DS = 2'd3;  // default segment

  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = 2;

  // single-byte opcodes matched exactly
  localparam byte_t OPC_CALLF = 8'h9A;
  localparam byte_t OPC_HLT   = 8'hF4;

  typedef enum logic [2:0] {
    ST_OPCODE,
    ST_MODRM,
    ST_OFFSET,
    ST_IMMED,
    ST_PUSH
  } fetch_state_e;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_ALU_RM,
    OP_ALU_ACC,
    OP_MOV_RM,
    OP_MOV_IMM,
    OP_PUSH,
    OP_POP,
    OP_JCC,
    OP_CALLF,
    OP_HLT
  } op_class_e;

  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_MOV
  } alu_op_e;

  typedef struct packed {
    op_class_e op_class;
    alu_op_e   alu_op;
    logic      byte_w;
    reg_code_t dst;
    reg_code_t src;
    logic      mem;
    reg_code_t base;
    reg_code_t index;
    seg_code_t seg;
    word_t     off;
    word_t     imm;
  } resolved_t;

endpackage
